// ==== verilog.f ====
+incdir+source
source/dma_group_pkg.sv
source/dma_spill_register.sv
source/dma_burst_splitter.sv
source/dma_group.sv
test/dma_group_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the DMA group testbench with Verilator and run it

set -u

cd "$(dirname "$0")" || exit 1

log=sim.log
sim=dma_group_sim

rm -rf obj_dir "$log"

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module dma_group_tb -o "$sim"
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/"$sim" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$log"; then
  echo "run.sh: simulation reported success"
  exit 0
else
  echo "run.sh: simulation did not report success"
  exit 1
fi

// ==== test/dma_group_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA group testbench
// Split bursts checked against per-port queues
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "dma_group_cfg.svh"

module dma_group_tb
  import dma_group_pkg::*;
();

  localparam int NB            = `DMA_NUM_BACKENDS;
  localparam int RANDOM_BURSTS = 40;

  logic                 clk;
  logic                 reset;
  dma_req_t             dma_req;
  logic                 dma_req_valid;
  logic                 dma_req_ready;
  dma_req_t  [NB-1:0]   backend_req;
  logic      [NB-1:0]   backend_valid;
  logic      [NB-1:0]   backend_ready;
  dma_meta_t [NB-1:0]   backend_meta;
  dma_meta_t            dma_meta;

  // Scoreboard, one queue of pieces per port
  dma_req_t             expected_q [NB][$];
  dma_req_t             exp_head [NB];
  logic      [NB-1:0]   exp_avail;
  // Handshake that the next rising edge completes
  logic      [NB-1:0]   xfer_seen;
  int                   busy_left [NB];
  logic                 random_ready;

  string                test_name;
  int                   errors;
  int                   tests_passed;
  int                   tests_failed;
  int                   cycle_count;
  int                   cycle_limit;
  dma_req_t             fixed_bursts [4];
  dma_req_t             random_bursts [RANDOM_BURSTS];

  dma_group UUT (
    .clk_i          (clk          ),
    .reset_i        (reset        ),
    .dma_req_i      (dma_req      ),
    .dma_req_valid_i(dma_req_valid),
    .dma_req_ready_o(dma_req_ready),
    .backend_req_o  (backend_req  ),
    .backend_valid_o(backend_valid),
    .backend_ready_i(backend_ready),
    .backend_meta_i (backend_meta ),
    .dma_meta_o     (dma_meta     )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic dma_req_t make_burst(logic [`DMA_ADDR_WIDTH-1:0] src,
                                          logic [`DMA_ADDR_WIDTH-1:0] dst,
                                          int unsigned len);
    dma_req_t b;
    b.src_addr  = src;
    b.dst_addr  = dst;
    b.num_bytes = `DMA_LEN_WIDTH'(len);
    return b;
  endfunction

  function automatic logic in_window(dma_req_t b);
    longint unsigned first;
    longint unsigned last;
    first = b.dst_addr;
    last  = first + b.num_bytes;
    return (first >= `DMA_TCDM_BASE) && (last <= `DMA_TCDM_BASE + `DMA_TCDM_SIZE);
  endfunction

  // Bytes from dst up to the region end, capped by what is left
  function automatic longint unsigned piece_bytes(longint unsigned dst, longint unsigned left);
    longint unsigned to_boundary;
    to_boundary = `DMA_REGION_BYTES - (dst % `DMA_REGION_BYTES);
    return (to_boundary < left) ? to_boundary : left;
  endfunction

  function automatic int piece_count(dma_req_t b);
    longint unsigned dst;
    longint unsigned left;
    longint unsigned step;
    int count;
    count = 0;
    if (!in_window(b)) begin
      count = 1;
    end else begin
      dst  = b.dst_addr;
      left = b.num_bytes;
      while (left > 0) begin
        step  = piece_bytes(dst, left);
        dst   = dst + step;
        left  = left - step;
        count = count + 1;
      end
    end
    return count;
  endfunction

  task automatic queue_expected(dma_req_t b);
    dma_req_t                   piece;
    logic [`DMA_ADDR_WIDTH-1:0] src;
    longint unsigned            dst;
    longint unsigned            left;
    longint unsigned            step;
    int                         port;
    if (!in_window(b)) begin
      expected_q[0].push_back(b);
    end else begin
      src  = b.src_addr;
      dst  = b.dst_addr;
      left = b.num_bytes;
      while (left > 0) begin
        step            = piece_bytes(dst, left);
        port            = int'((dst / `DMA_REGION_BYTES) % NB);
        piece.src_addr  = src;
        piece.dst_addr  = `DMA_ADDR_WIDTH'(dst);
        piece.num_bytes = `DMA_LEN_WIDTH'(step);
        expected_q[port].push_back(piece);
        src  = src + `DMA_ADDR_WIDTH'(step);
        dst  = dst + step;
        left = left - step;
      end
    end
  endtask

  // Backend models: ready pattern, busy hold and queue heads
  initial begin
    backend_ready = '1;
    backend_meta  = '0;
    xfer_seen     = '0;
    exp_avail     = '0;
    for (int p = 0; p < NB; p++) begin
      busy_left[p] = 0;
    end
    forever begin
      @(negedge clk);
      for (int p = 0; p < NB; p++) begin
        if (reset) begin
          busy_left[p] = 0;
          xfer_seen[p] = 1'b0;
        end else if (xfer_seen[p]) begin
          if (expected_q[p].size() > 0) begin
            void'(expected_q[p].pop_front());
          end
          busy_left[p] = $urandom_range(5, 0);
        end else if (busy_left[p] > 0) begin
          busy_left[p] = busy_left[p] - 1;
        end
        backend_meta[p].busy = busy_left[p] != 0;
        backend_ready[p]     = random_ready ? ($urandom_range(3, 0) != 0) : 1'b1;
        xfer_seen[p]         = !reset && backend_valid[p] && backend_ready[p];
        exp_avail[p]         = expected_q[p].size() > 0;
        if (exp_avail[p]) begin
          exp_head[p] = expected_q[p][0];
        end
      end
    end
  end

  for (genvar p = 0; p < NB; p++) begin : gen_port_checks
    a_piece_expected: assert property (@(posedge clk) disable iff (reset)
      backend_valid[p] && backend_ready[p] |-> exp_avail[p])
      else begin
        $display("test %s: port %0d accepted a piece that no burst should produce",
                 test_name, p);
        errors++;
      end

    a_piece_match: assert property (@(posedge clk) disable iff (reset)
      backend_valid[p] && backend_ready[p] && exp_avail[p] |-> backend_req[p] == exp_head[p])
      else begin
        $display("ERROR test %s port %0d: expected src %h dst %h len %0d, actual src %h dst %h len %0d",
                 test_name, p, exp_head[p].src_addr, exp_head[p].dst_addr,
                 exp_head[p].num_bytes, backend_req[p].src_addr, backend_req[p].dst_addr,
                 backend_req[p].num_bytes);
        errors++;
      end

    a_piece_stable: assert property (@(posedge clk) disable iff (reset)
      backend_valid[p] && !backend_ready[p] |=> backend_valid[p] && $stable(backend_req[p]))
      else begin
        $display("test %s: port %0d piece changed or vanished while stalled", test_name, p);
        errors++;
      end
  end

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_burst(dma_req_t b);
    dma_req       = b;
    dma_req_valid = 1'b1;
    while (!dma_req_ready) begin
      @(negedge clk);
    end
    queue_expected(b);
    @(negedge clk);
    dma_req_valid = 1'b0;
  endtask

  function automatic logic all_idle();
    logic idle;
    idle = 1'b1;
    for (int p = 0; p < NB; p++) begin
      idle = idle && (expected_q[p].size() == 0) && (busy_left[p] == 0) && !xfer_seen[p];
    end
    return idle;
  endfunction

  task automatic wait_drain();
    do begin
      @(posedge clk);
    end while (!all_idle());
  endtask

  task automatic finish_test(int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("test %s: pass", test_name);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", test_name, errors - errors_before);
    end
  endtask

  task automatic run_single(string name, dma_req_t b);
    int errors_before;
    test_name     = name;
    errors_before = errors;
    send_burst(b);
    wait_drain();
    @(negedge clk);
    finish_test(errors_before);
  endtask

  task automatic check_busy_rises();
    int waited;
    waited = 0;
    while (!dma_meta.busy && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    assert (dma_meta.busy)
      else begin
        $display("test %s: group busy did not rise after the burst was accepted", test_name);
        errors++;
      end
  endtask

  initial begin
    int unsigned total;
    int          errors_before;
    void'($urandom(32'heb82_34c7));
    reset         = 1'b1;
    dma_req       = '0;
    dma_req_valid = 1'b0;
    random_ready  = 1'b0;
    errors        = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    test_name     = "reset";

    fixed_bursts[0] = make_burst(32'h8000_0000, 32'h0000_0104, 32);
    fixed_bursts[1] = make_burst(32'h1000_0010, 32'h0000_0348, 16);
    fixed_bursts[2] = make_burst(32'h2000_0004, 32'h0000_0a2c, 200);
    fixed_bursts[3] = make_burst(32'h3000_0100, 32'h0000_0fc0, 128);
    for (int i = 0; i < RANDOM_BURSTS; i++) begin
      random_bursts[i].src_addr = $urandom() & 32'hffff_fffc;
      // About one in eight lands outside the window
      if ($urandom_range(7, 0) == 0) begin
        random_bursts[i].dst_addr = 32'h0000_2000 + ($urandom_range(255, 0) * 4);
      end else begin
        random_bursts[i].dst_addr = $urandom_range(32'h0fff, 0) & 32'hffff_fffc;
      end
      random_bursts[i].num_bytes = `DMA_LEN_WIDTH'($urandom_range(96, 1) * 4);
    end
    total = 0;
    for (int i = 0; i < 4; i++) begin
      total += piece_count(fixed_bursts[i]);
    end
    for (int i = 0; i < RANDOM_BURSTS; i++) begin
      total += piece_count(random_bursts[i]);
    end
    cycle_limit = 20 * total + 200;

    repeat (2) @(negedge clk);
    reset = 1'b0;

    test_name     = "busy_status";
    errors_before = errors;
    assert (!dma_meta.busy)
      else begin
        $display("test %s: group busy is high right after reset", test_name);
        errors++;
      end
    send_burst(fixed_bursts[0]);
    check_busy_rises();
    wait_drain();
    @(posedge clk);
    @(negedge clk);
    assert (!dma_meta.busy)
      else begin
        $display("test %s: group busy still high with every port idle", test_name);
        errors++;
      end
    finish_test(errors_before);

    run_single("single_region", fixed_bursts[1]);
    run_single("multi_region", fixed_bursts[2]);
    run_single("outside_window", fixed_bursts[3]);

    test_name     = "back_pressure";
    errors_before = errors;
    random_ready  = 1'b1;
    for (int i = 0; i < RANDOM_BURSTS; i++) begin
      send_burst(random_bursts[i]);
    end
    wait_drain();
    @(negedge clk);
    random_ready = 1'b0;
    finish_test(errors_before);

    $display("tests: %0d passed, %0d failed, %0d check errors",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycle_count = 0;
    @(posedge clk);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run exceeded %0d cycles during test %s", cycle_limit, test_name);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== source/dma_group.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA group
// Input cut, burst splitter, port cuts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "dma_group_cfg.svh"

module dma_group
  import dma_group_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                reset_i,
  // Burst request
  input  dma_req_t                            dma_req_i,
  input  logic                                dma_req_valid_i,
  output logic                                dma_req_ready_o,
  // Backend ports
  output dma_req_t  [`DMA_NUM_BACKENDS-1:0]   backend_req_o,
  output logic      [`DMA_NUM_BACKENDS-1:0]   backend_valid_o,
  input  logic      [`DMA_NUM_BACKENDS-1:0]   backend_ready_i,
  input  dma_meta_t [`DMA_NUM_BACKENDS-1:0]   backend_meta_i,
  // Group status
  output dma_meta_t                           dma_meta_o
);

  dma_req_t                        burst;
  logic                            burst_valid;
  logic                            burst_ready;

  dma_req_t                        piece;
  logic [`DMA_NUM_BACKENDS-1:0]    piece_valid;
  logic [`DMA_NUM_BACKENDS-1:0]    piece_ready;

  // Bit 0 is the input cut, bit p+1 the cut of port p
  logic [`DMA_NUM_BACKENDS:0]      cuts_occupied;

  dma_spill_register #(
    .T(dma_req_t)
  ) i_dma_req_register (
    .clk_i     (clk_i           ),
    .reset_i   (reset_i         ),
    .data_i    (dma_req_i       ),
    .valid_i   (dma_req_valid_i ),
    .ready_o   (dma_req_ready_o ),
    .data_o    (burst           ),
    .valid_o   (burst_valid     ),
    .ready_i   (burst_ready     ),
    .occupied_o(cuts_occupied[0])
  );

  dma_burst_splitter i_dma_burst_splitter (
    .clk_i          (clk_i         ),
    .reset_i        (reset_i       ),
    .burst_i        (burst         ),
    .burst_valid_i  (burst_valid   ),
    .burst_ready_o  (burst_ready   ),
    .piece_o        (piece         ),
    .piece_sel_o    (              ),
    .piece_valid_o  (piece_valid   ),
    .piece_ready_i  (piece_ready   ),
    .cuts_occupied_i(cuts_occupied ),
    .backend_meta_i (backend_meta_i),
    .meta_o         (dma_meta_o    )
  );

  for (genvar p = 0; p < `DMA_NUM_BACKENDS; p++) begin : gen_backend_cuts
    dma_spill_register #(
      .T(dma_req_t)
    ) i_backend_register (
      .clk_i     (clk_i               ),
      .reset_i   (reset_i             ),
      .data_i    (piece               ),
      .valid_i   (piece_valid[p]      ),
      .ready_o   (piece_ready[p]      ),
      .data_o    (backend_req_o[p]    ),
      .valid_o   (backend_valid_o[p]  ),
      .ready_i   (backend_ready_i[p]  ),
      .occupied_o(cuts_occupied[p + 1])
    );
  end

endmodule

// ==== source/dma_burst_splitter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA burst splitter
// Cuts bursts at region boundaries, routes
// each piece to its backend, merges busy
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "dma_group_cfg.svh"

module dma_burst_splitter
  import dma_group_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  dma_req_t                            burst_i,
  input  logic                                burst_valid_i,
  output logic                                burst_ready_o,
  output dma_req_t                            piece_o,
  output backend_sel_t                        piece_sel_o,
  output logic      [`DMA_NUM_BACKENDS-1:0]   piece_valid_o,
  input  logic      [`DMA_NUM_BACKENDS-1:0]   piece_ready_i,
  input  logic      [`DMA_NUM_BACKENDS:0]     cuts_occupied_i,
  input  dma_meta_t [`DMA_NUM_BACKENDS-1:0]   backend_meta_i,
  output dma_meta_t                           meta_o
);

  localparam int unsigned region_bits = $clog2(`DMA_REGION_BYTES);
  localparam int unsigned sel_bits    = $bits(backend_sel_t);
  localparam int unsigned end_width   = `DMA_ADDR_WIDTH + 1;

  // Remaining part of the burst being split
  logic                       active_q;
  logic                       inside_q;
  logic [`DMA_ADDR_WIDTH-1:0] src_q;
  logic [`DMA_ADDR_WIDTH-1:0] dst_q;
  logic [`DMA_LEN_WIDTH-1:0]  left_q;

  logic [`DMA_ADDR_WIDTH-1:0] burst_rel;
  logic [end_width-1:0]       burst_end;
  logic                       burst_inside;
  logic                       burst_take;

  logic [`DMA_LEN_WIDTH-1:0]  room;
  logic [`DMA_LEN_WIDTH-1:0]  piece_len;
  logic                       piece_fire;
  logic                       piece_last;

  logic                       busy_d;
  dma_meta_t                  meta_q;

  // Window check on the incoming burst, relative to the window base.
  // A start below the base wraps to a huge offset and fails the check.
  assign burst_rel    = burst_i.dst_addr - `DMA_TCDM_BASE;
  assign burst_end    = end_width'(burst_rel) + end_width'(burst_i.num_bytes);
  assign burst_inside = burst_end <= end_width'(`DMA_TCDM_SIZE);

  // Bytes up to the next region boundary
  assign room = `DMA_LEN_WIDTH'(`DMA_REGION_BYTES)
              - `DMA_LEN_WIDTH'(dst_q[region_bits-1:0]);

  // Outside bursts go whole
  assign piece_len = (inside_q && (room < left_q)) ? room : left_q;

  // Port owning the current region
  assign piece_sel_o = inside_q ? dst_q[region_bits +: sel_bits] : '0;

  assign piece_o.src_addr  = src_q;
  assign piece_o.dst_addr  = dst_q;
  assign piece_o.num_bytes = piece_len;

  always_comb begin
    piece_valid_o = '0;
    if (active_q) begin
      piece_valid_o[piece_sel_o] = 1'b1;
    end
  end

  assign piece_fire = active_q && piece_ready_i[piece_sel_o];
  assign piece_last = piece_len == left_q;

  // Next burst may enter as the last piece leaves
  assign burst_ready_o = !active_q || (piece_fire && piece_last);
  assign burst_take    = burst_valid_i && burst_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q <= 1'b0;
    end else if (burst_take) begin
      active_q <= 1'b1;
    end else if (piece_fire && piece_last) begin
      active_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (burst_take) begin
      src_q    <= burst_i.src_addr;
      dst_q    <= burst_i.dst_addr;
      left_q   <= burst_i.num_bytes;
      inside_q <= burst_inside;
    end else if (piece_fire) begin
      // src follows dst by the same stride
      src_q  <= src_q + `DMA_ADDR_WIDTH'(piece_len);
      dst_q  <= dst_q + `DMA_ADDR_WIDTH'(piece_len);
      left_q <= left_q - piece_len;
    end
  end

  // Group busy: splitter, any cut, any backend
  always_comb begin
    busy_d = active_q || (|cuts_occupied_i);
    for (int unsigned p = 0; p < `DMA_NUM_BACKENDS; p++) begin
      busy_d = busy_d || backend_meta_i[p].busy;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      meta_q <= '0;
    end else begin
      meta_q.busy <= busy_d;
    end
  end

  assign meta_o = meta_q;

  a_burst_len: assert property (@(posedge clk_i) disable iff (reset_i)
    burst_take |-> (burst_i.num_bytes != '0) && (burst_i.num_bytes[1:0] == 2'b00))
    else $error("burst length must be a nonzero multiple of 4");

  a_one_port: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(piece_valid_o))
    else $error("piece offered on more than one port");

endmodule

// ==== source/dma_spill_register.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Spill register
// Two-slot valid/ready cut, any payload
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module dma_spill_register #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic reset_i,
  input  T     data_i,
  input  logic valid_i,
  output logic ready_o,
  output T     data_o,
  output logic valid_o,
  input  logic ready_i,
  output logic occupied_o
);

  // Slot a takes new data, slot b catches it on a stall
  T     a_data_q;
  logic a_full_q;
  T     b_data_q;
  logic b_full_q;

  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Ready only drops with both slots taken
  assign ready_o    = !a_full_q || !b_full_q;
  assign valid_o    = a_full_q || b_full_q;
  // Older entry sits in b
  assign data_o     = b_full_q ? b_data_q : a_data_q;
  assign occupied_o = a_full_q || b_full_q;

  a_hold_stalled: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("spill register output changed while stalled");

endmodule

// ==== source/dma_group_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA group types
// Burst request, backend status, port index
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "dma_group_cfg.svh"

package dma_group_pkg;

  // One 1D transfer, also used for every piece
  typedef struct packed {
    logic [`DMA_ADDR_WIDTH-1:0] src_addr;
    logic [`DMA_ADDR_WIDTH-1:0] dst_addr;
    logic [`DMA_LEN_WIDTH-1:0]  num_bytes;
  } dma_req_t;

  // Status reported by a backend and by the group
  typedef struct packed {
    logic busy;
  } dma_meta_t;

  // Backend port index
  typedef logic [$clog2(`DMA_NUM_BACKENDS)-1:0] backend_sel_t;

endpackage

// ==== source/dma_group_cfg.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA group configuration
// Backend count, region layout, widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef DMA_GROUP_CFG_SVH
`define DMA_GROUP_CFG_SVH

// Backend ports fed by the splitter
`define DMA_NUM_BACKENDS 4

// Interleaved region owned by one backend, power of two
`define DMA_REGION_BYTES 64

// Distributed TCDM window
`define DMA_TCDM_BASE 32'h0000_0000
`define DMA_TCDM_SIZE 32'h0000_1000

// Request field widths
`define DMA_ADDR_WIDTH 32
`define DMA_LEN_WIDTH 16

`endif
